// File: common/rob_params.svh
`ifndef ROB_PARAMS_SVH
`define ROB_PARAMS_SVH

// buffer geometry
`define ROB_SZ       16
`define ROB_N        2
`define CDB_SZ       2
`define ALERT_DEPTH  `ROB_N

// register files
`define ARCH_REGS    32
`define PHYS_REGS    64

// field widths
`define XLEN         32
`define ROB_IDX_W    4
`define ROB_CNT_W    5
`define ARN_W        5
`define PRN_W        6

`endif

// File: common/rob_pkg.sv
`include "rob_params.svh"

package rob_pkg;

    typedef logic [`ROB_IDX_W-1:0] robn_t;
    typedef logic [`ARN_W-1:0]     arn_t;
    typedef logic [`PRN_W-1:0]     prn_t;
    typedef logic [`XLEN-1:0]      addr_t;

    typedef struct packed {
        logic  executed;
        logic  success;        // resolved direction matched prediction
        logic  cond_branch;
        logic  uncond_branch;
        logic  has_dest;
        logic  predict_taken;
        logic  resolve_taken;
        arn_t  dest_arn;
        prn_t  dest_prn;
        addr_t pc;
        addr_t npc;            // resolved target once executed
    } rob_entry_t;

    typedef struct packed {
        logic [`ROB_N-1:0]       valid;
        rob_entry_t [`ROB_N-1:0] entries;
    } dispatch_packet_t;

    typedef struct packed {
        logic  executed;
        robn_t robn;
        logic  branch_taken;
        addr_t target_addr;
    } cdb_packet_t;

    typedef struct packed {
        logic  valid;
        logic  has_dest;
        arn_t  dest_arn;
        prn_t  dest_prn;
        addr_t pc;
    } commit_slot_t;

    typedef struct packed {
        commit_slot_t [`ROB_N-1:0] slots;   // slot 0 is oldest
    } commit_packet_t;

endpackage

// File: rob/rob.sv
`timescale 1ns/1ps
`include "rob_params.svh"

module rob #(
    parameter int DEPTH       = `ROB_SZ,
    parameter int ALERT_DEPTH = `ALERT_DEPTH
) (
    input  logic                                 clock,
    input  logic                                 reset,
    input  rob_pkg::dispatch_packet_t            dispatch,
    input  rob_pkg::cdb_packet_t [`CDB_SZ-1:0]   completion,
    output logic                                 almost_full,
    output rob_pkg::commit_packet_t              commit,
    output rob_pkg::robn_t [`ROB_N-1:0]          tail_entries,
    output logic                                 squash,
    output rob_pkg::addr_t                       squash_pc
);
    import rob_pkg::*;

    localparam int CNT_W = `ROB_CNT_W;
    localparam logic [CNT_W-1:0] ALERT_LEVEL = CNT_W'(DEPTH - ALERT_DEPTH);

    robn_t            head, next_head;
    robn_t            tail, next_tail;
    logic [CNT_W-1:0] count, next_count;

    rob_entry_t [DEPTH-1:0] entries, next_entries;

    // circular increment for any depth
    function automatic robn_t next_ptr(input robn_t ptr);
        if (ptr == robn_t'(DEPTH - 1)) begin
            return '0;
        end
        return ptr + 1'b1;
    endfunction

    assign almost_full = (count > ALERT_LEVEL);   // registered count only

    always_comb begin
        rob_entry_t new_entry;
        robn_t      idx;
        robn_t      proj;
        logic       blocked;

        next_head    = head;
        next_tail    = tail;
        next_count   = count;
        next_entries = entries;
        commit       = '0;
        squash       = 1'b0;
        squash_pc    = '0;
        blocked      = 1'b0;
        new_entry    = '0;
        idx          = '0;
        proj         = '0;

        // in-order commit from head
        for (int i = 0; i < `ROB_N; i++) begin
            if (!blocked && next_count != '0 && entries[next_head].executed) begin
                if (entries[next_head].success) begin
                    commit.slots[i].valid    = 1'b1;
                    commit.slots[i].has_dest = entries[next_head].has_dest;
                    commit.slots[i].dest_arn = entries[next_head].dest_arn;
                    commit.slots[i].dest_prn = entries[next_head].dest_prn;
                    commit.slots[i].pc       = entries[next_head].pc;
                    next_head  = next_ptr(next_head);
                    next_count = next_count - 1'b1;
                end else begin
                    // mispredicted head flushes everything younger
                    squash     = 1'b1;
                    squash_pc  = entries[next_head].npc;
                    next_head  = '0;
                    next_tail  = '0;
                    next_count = '0;
                    blocked    = 1'b1;
                end
            end else begin
                blocked = 1'b1;   // nothing after a stalled slot commits
            end
        end

        // dispatch takes the whole group or nothing
        if (!almost_full && !squash) begin
            for (int i = 0; i < `ROB_N; i++) begin
                if (dispatch.valid[i]) begin
                    new_entry          = dispatch.entries[i];
                    new_entry.executed = 1'b0;
                    new_entry.success  = 1'b0;
                    next_entries[next_tail] = new_entry;
                    next_tail  = next_ptr(next_tail);
                    next_count = next_count + 1'b1;
                end
            end
        end

        // completion reports
        for (int i = 0; i < `CDB_SZ; i++) begin
            if (completion[i].executed) begin
                idx = completion[i].robn;
                next_entries[idx].executed      = 1'b1;
                next_entries[idx].resolve_taken = completion[i].branch_taken;
                next_entries[idx].success       =
                    (completion[i].branch_taken == next_entries[idx].predict_taken);
                next_entries[idx].npc           = completion[i].target_addr;
            end
        end

        // slots the next group lands in
        proj = next_tail;
        for (int i = 0; i < `ROB_N; i++) begin
            tail_entries[i] = proj;
            proj = next_ptr(proj);
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            head  <= '0;
            tail  <= '0;
            count <= '0;
        end else begin
            head  <= next_head;
            tail  <= next_tail;
            count <= next_count;
        end
    end

    // entry payload
    always_ff @(posedge clock) begin
        entries <= next_entries;
    end

endmodule

// File: hdl/retire_map.sv
`timescale 1ns/1ps
`include "rob_params.svh"

module retire_map (
    input  logic                    clock,
    input  logic                    reset,
    input  rob_pkg::commit_packet_t commit,
    input  rob_pkg::arn_t           lookup_arn,
    output rob_pkg::prn_t           lookup_prn
);
    import rob_pkg::*;

    prn_t map [`ARCH_REGS];

    // async read of committed mapping
    assign lookup_prn = map[lookup_arn];

    always_ff @(posedge clock) begin
        if (reset) begin
            for (int k = 0; k < `ARCH_REGS; k++) begin
                map[k] <= prn_t'(k);   // identity
            end
        end else begin
            // slot order, younger slot overrides
            for (int i = 0; i < `ROB_N; i++) begin
                if (commit.slots[i].valid && commit.slots[i].has_dest) begin
                    map[commit.slots[i].dest_arn] <= commit.slots[i].dest_prn;
                end
            end
        end
    end

endmodule

// File: hdl/rob_top.sv
`timescale 1ns/1ps
`include "rob_params.svh"

module rob_top (
    input  logic                                 clock,
    input  logic                                 reset,
    input  rob_pkg::dispatch_packet_t            dispatch,
    input  rob_pkg::cdb_packet_t [`CDB_SZ-1:0]   completion,
    input  rob_pkg::arn_t                        lookup_arn,
    output logic                                 almost_full,
    output rob_pkg::commit_packet_t              commit,
    output rob_pkg::robn_t [`ROB_N-1:0]          tail_entries,
    output logic                                 squash,
    output rob_pkg::addr_t                       squash_pc,
    output rob_pkg::prn_t                        lookup_prn
);

    rob #(
        .DEPTH       (`ROB_SZ),
        .ALERT_DEPTH (`ALERT_DEPTH)
    ) i_rob (
        .clock        (clock),
        .reset        (reset),
        .dispatch     (dispatch),
        .completion   (completion),
        .almost_full  (almost_full),
        .commit       (commit),
        .tail_entries (tail_entries),
        .squash       (squash),
        .squash_pc    (squash_pc)
    );

    // commit packet also feeds the retirement map
    retire_map i_retire_map (
        .clock      (clock),
        .reset      (reset),
        .commit     (commit),
        .lookup_arn (lookup_arn),
        .lookup_prn (lookup_prn)
    );

endmodule

// File: bench/rob_tb.sv
`timescale 1ns/1ps
`include "rob_params.svh"

module rob_tb;
    import rob_pkg::*;

    localparam int    DEPTH     = `ROB_SZ;
    localparam string STIM_FILE = "bench/rob_stimulus.txt";

    logic                      clock;
    logic                      reset;
    dispatch_packet_t          dispatch;
    cdb_packet_t [`CDB_SZ-1:0] completion;
    arn_t                      lookup_arn;
    logic                      almost_full;
    commit_packet_t            commit;
    robn_t [`ROB_N-1:0]        tail_entries;
    logic                      squash;
    addr_t                     squash_pc;
    prn_t                      lookup_prn;

    rob_entry_t       model_q[$];   // occupied entries, oldest first
    int               model_head;
    int               fd;
    int               line_count;
    logic [8*32-1:0]  test_name;
    int               test_errors;
    int               total_errors;
    int               tests_run;
    int               tests_failed;

    rob_top i_rob_top (
        .clock        (clock),
        .reset        (reset),
        .dispatch     (dispatch),
        .completion   (completion),
        .lookup_arn   (lookup_arn),
        .almost_full  (almost_full),
        .commit       (commit),
        .tail_entries (tail_entries),
        .squash       (squash),
        .squash_pc    (squash_pc),
        .lookup_prn   (lookup_prn)
    );

    always #50 clock = ~clock;

    task automatic report_mismatch(input string what, input logic [63:0] expected,
                                   input logic [63:0] actual);
        $display("Mismatch in %0s: %0s expected %h actual %h", test_name, what, expected, actual);
        test_errors++;
    endtask

    task automatic close_test();
        if (test_name != '0) begin
            if (test_errors == 0) begin
                $display("test %0s passed", test_name);
            end else begin
                $display("test %0s failed with %0d errors", test_name, test_errors);
                tests_failed++;
            end
            tests_run++;
        end
        total_errors += test_errors;
        test_errors = 0;
    endtask

    task automatic clear_inputs();
        dispatch   = '0;
        completion = '0;
        lookup_arn = '0;
    endtask

    // one cycle of the reference model, checked against the DUT
    task automatic model_step();
        commit_packet_t exp_commit;
        rob_entry_t     e;
        logic           exp_full;
        logic           exp_squash;
        addr_t          exp_squash_pc;
        logic           blocked;
        int             pos;
        int             tail;
        exp_commit    = '0;
        exp_squash    = 1'b0;
        exp_squash_pc = '0;
        blocked       = 1'b0;
        exp_full      = model_q.size() > DEPTH - `ALERT_DEPTH;
        for (int i = 0; i < `ROB_N; i++) begin
            if (!blocked && model_q.size() != 0 && model_q[0].executed) begin
                if (model_q[0].success) begin
                    exp_commit.slots[i].valid    = 1'b1;
                    exp_commit.slots[i].has_dest = model_q[0].has_dest;
                    exp_commit.slots[i].dest_arn = model_q[0].dest_arn;
                    exp_commit.slots[i].dest_prn = model_q[0].dest_prn;
                    exp_commit.slots[i].pc       = model_q[0].pc;
                    void'(model_q.pop_front());
                    model_head = (model_head + 1) % DEPTH;
                end else begin
                    exp_squash    = 1'b1;   // flush, pointers back to 0
                    exp_squash_pc = model_q[0].npc;
                    model_q.delete();
                    model_head    = 0;
                    blocked       = 1'b1;
                end
            end else begin
                blocked = 1'b1;
            end
        end
        if (almost_full !== exp_full) report_mismatch("almost_full", exp_full, almost_full);
        if (squash !== exp_squash) report_mismatch("squash", exp_squash, squash);
        if (exp_squash && squash_pc !== exp_squash_pc) begin
            report_mismatch("squash_pc", exp_squash_pc, squash_pc);
        end
        for (int i = 0; i < `ROB_N; i++) begin
            if (commit.slots[i] !== exp_commit.slots[i]) begin
                report_mismatch("commit slot", exp_commit.slots[i], commit.slots[i]);
            end
        end
        if (!exp_full && !exp_squash) begin
            for (int i = 0; i < `ROB_N; i++) begin
                if (dispatch.valid[i]) begin
                    e          = dispatch.entries[i];
                    e.executed = 1'b0;
                    e.success  = 1'b0;
                    model_q.push_back(e);
                end
            end
        end
        for (int i = 0; i < `CDB_SZ; i++) begin
            pos = (int'(completion[i].robn) - model_head + DEPTH) % DEPTH;
            if (completion[i].executed && pos < model_q.size()) begin
                model_q[pos].executed      = 1'b1;
                model_q[pos].resolve_taken = completion[i].branch_taken;
                model_q[pos].success = (completion[i].branch_taken == model_q[pos].predict_taken);
                model_q[pos].npc           = completion[i].target_addr;
            end
        end
        tail = (model_head + model_q.size()) % DEPTH;
        for (int i = 0; i < `ROB_N; i++) begin
            if (tail_entries[i] !== robn_t'((tail + i) % DEPTH)) begin
                report_mismatch("tail_entries", (tail + i) % DEPTH, tail_entries[i]);
            end
        end
    endtask

    // reads one command line, drives it for a cycle and checks the result
    task automatic run_cycle(input logic [8*16-1:0] cmd);
        logic [7:0]       mask;
        logic [8*128-1:0] rest;
        addr_t            pc;
        addr_t            exp_pc [`ROB_N];
        addr_t            exp_sq_pc;
        logic             hd;
        logic             pred;
        arn_t             arn;
        prn_t             prn;
        robn_t            t0;
        robn_t            t1;
        int               n;
        int               r;
        clear_inputs();
        n = 0;
        if (cmd == "dispatch") begin
            r = $fscanf(fd, "%h", mask);
            dispatch.valid = mask[`ROB_N-1:0];
            for (int i = 0; i < `ROB_N; i++) begin
                r = $fscanf(fd, "%h %h %h %h %h", pc, hd, arn, prn, pred);
                dispatch.entries[i].pc            = pc;
                dispatch.entries[i].has_dest      = hd;
                dispatch.entries[i].dest_arn      = arn;
                dispatch.entries[i].dest_prn      = prn;
                dispatch.entries[i].predict_taken = pred;
            end
        end else if (cmd == "complete") begin
            r = $fscanf(fd, "%h", n);
            for (int i = 0; i < n; i++) begin
                r = $fscanf(fd, "%h %h %h", t0, hd, pc);
                completion[i].executed     = 1'b1;
                completion[i].robn         = t0;
                completion[i].branch_taken = hd;
                completion[i].target_addr  = pc;
            end
        end else if (cmd == "lookup") begin
            r = $fscanf(fd, "%h %h", arn, prn);
            lookup_arn = arn;
        end else if (cmd == "expect_tail") begin
            r = $fscanf(fd, "%h %h", t0, t1);
        end else if (cmd == "expect_squash") begin
            r = $fscanf(fd, "%h", exp_sq_pc);
        end else if (cmd != "expect_commit" && cmd != "idle") begin
            $display("unknown stimulus command %0s in test %0s", cmd, test_name);
            test_errors++;
            r = $fgets(rest, fd);
        end
        if (cmd == "expect_commit" || cmd == "expect_squash") begin
            r = $fscanf(fd, "%h", n);
            for (int i = 0; i < n; i++) begin
                r = $fscanf(fd, "%h", pc);
                exp_pc[i] = pc;
            end
        end
        #10;   // let the combinational outputs settle
        model_step();
        if (cmd == "lookup" && lookup_prn !== prn) report_mismatch("lookup_prn", prn, lookup_prn);
        if (cmd == "expect_tail" && tail_entries[0] !== t0) begin
            report_mismatch("tail_entries[0]", t0, tail_entries[0]);
        end
        if (cmd == "expect_tail" && tail_entries[1] !== t1) begin
            report_mismatch("tail_entries[1]", t1, tail_entries[1]);
        end
        if (cmd == "expect_squash" && squash !== 1'b1) report_mismatch("squash", 1, squash);
        if (cmd == "expect_squash" && squash_pc !== exp_sq_pc) begin
            report_mismatch("squash_pc", exp_sq_pc, squash_pc);
        end
        if (cmd == "expect_commit" || cmd == "expect_squash") begin
            for (int i = 0; i < `ROB_N; i++) begin
                if (i < n && commit.slots[i].valid !== 1'b1) begin
                    report_mismatch("commit valid", 1, commit.slots[i].valid);
                end else if (i < n && commit.slots[i].pc !== exp_pc[i]) begin
                    report_mismatch("commit pc", exp_pc[i], commit.slots[i].pc);
                end else if (i >= n && commit.slots[i].valid !== 1'b0) begin
                    report_mismatch("commit valid", 0, commit.slots[i].valid);
                end
            end
        end
        @(negedge clock);
    endtask

    task automatic run_file();
        logic [8*16-1:0]  cmd;
        logic [8*128-1:0] rest;
        int               r;
        r = $fscanf(fd, "%s", cmd);
        while (r == 1) begin
            if (cmd == "#") begin
                r = $fgets(rest, fd);   // comment line
            end else if (cmd == "test") begin
                close_test();
                r = $fscanf(fd, "%s", test_name);
            end else begin
                run_cycle(cmd);
            end
            r = $fscanf(fd, "%s", cmd);
        end
    endtask

    task automatic count_lines();
        logic [8*128-1:0] text;
        int               cfd;
        int               lines;
        lines = 0;
        cfd   = $fopen(STIM_FILE, "r");
        if (cfd != 0) begin
            while ($fgets(text, cfd) != 0) begin
                lines++;
            end
            $fclose(cfd);
        end
        line_count = lines;
    endtask

    initial begin
        clock        = 1'b0;
        reset        = 1'b1;
        test_name    = '0;
        test_errors  = 0;
        total_errors = 0;
        tests_run    = 0;
        tests_failed = 0;
        model_head   = 0;
        clear_inputs();
        count_lines();
        fd = $fopen(STIM_FILE, "r");
        if (fd == 0) begin
            $display("could not open the stimulus file %0s", STIM_FILE);
            $display("TEST FAILED");
            $finish;
        end else begin
            repeat (4) @(posedge clock);
            @(negedge clock);
            reset = 1'b0;
            run_file();
            close_test();
            $fclose(fd);
            $display("%0d tests run, %0d failed, %0d errors", tests_run, tests_failed,
                     total_errors);
            if (total_errors == 0) begin
                $display("TEST PASSED");
            end else begin
                $display("TEST FAILED");
            end
            $finish;
        end
    end

    // 20 cycles of budget per stimulus line
    initial begin
        wait (line_count > 0);
        #(line_count * 20 * 100);
        $display("timeout, the stimulus did not finish within %0d cycles", line_count * 20);
        $display("TEST FAILED");
        $finish;
    end

endmodule

// File: bench/rob_stimulus.txt
# all numbers hex; dispatch mask pc0 dest0 arn0 prn0 pred0 pc1 dest1 arn1 prn1 pred1
# complete n {robn taken target}, expect_commit n {pc}, expect_squash target n {pc}
# lookup arn prn, expect_tail t0 t1, idle
test reset_state
lookup 00 00
lookup 1f 1f
expect_tail 0 1
test ordered_commit
dispatch 3 100 1 01 20 0 104 1 02 21 0
dispatch 3 108 1 01 22 0 10c 1 03 23 0
complete 2 3 0 110 2 0 10c
expect_commit 0
complete 1 1 0 108
expect_commit 0
complete 1 0 0 104
expect_commit 2 100 104
expect_commit 2 108 10c
expect_commit 0
test retire_map
lookup 01 22
lookup 02 21
lookup 04 04
dispatch 3 110 1 05 30 0 114 1 05 31 0
complete 2 4 0 114 5 0 118
expect_commit 2 110 114
lookup 05 31
dispatch 1 118 1 06 32 0 0 0 00 00 0
complete 1 6 0 11c
expect_commit 1 118
lookup 06 32
test back_pressure
dispatch 3 200 0 00 00 0 204 0 00 00 0
dispatch 3 208 0 00 00 0 20c 0 00 00 0
dispatch 3 210 0 00 00 0 214 0 00 00 0
dispatch 3 218 0 00 00 0 21c 0 00 00 0
dispatch 3 220 0 00 00 0 224 0 00 00 0
dispatch 3 228 0 00 00 0 22c 0 00 00 0
dispatch 3 230 0 00 00 0 234 0 00 00 0
dispatch 3 238 0 00 00 0 23c 0 00 00 0
dispatch 3 240 0 00 00 0 244 0 00 00 0
expect_tail 7 8
complete 2 7 0 204 8 0 208
expect_commit 2 200 204
dispatch 3 240 0 00 00 0 244 0 00 00 0
expect_tail 9 a
test misprediction
complete 2 9 0 20c a 1 400
expect_squash 400 1 208
expect_tail 0 1
expect_commit 0
test tail_projection
dispatch 2 0 0 00 00 0 504 0 00 00 0
dispatch 3 508 0 00 00 0 50c 0 00 00 1
expect_tail 3 4
complete 2 0 0 508 1 0 50c
expect_commit 2 504 508
complete 1 2 1 600
expect_commit 1 50c
expect_commit 0

// File: compile.f
+incdir+common
common/rob_pkg.sv
rob/rob.sv
hdl/retire_map.sv
hdl/rob_top.sv
bench/rob_tb.sv

// File: run.sh
#!/bin/sh
# build and run the reorder buffer testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal --top-module rob_tb -f compile.f -Mdir obj_dir
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

output=$(./obj_dir/Vrob_tb)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -q "^TEST PASSED$"; then
    exit 0
fi
exit 1
